/* compile.f */
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/insDecoder.sv
hw/microSequencer.sv
hw/ctrlEncoder.sv
hw/cpuControl.sv
tb/cpuControl_assert.sv
tb/cpuControlTb.sv

/* hw/cpuControl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuControl (
    input  logic             Clk,
    input  logic             rstN,
    input  isaPkg::insT      ir,
    input  logic             z,
    output logic             iromRead,
    output logic             memRead,
    output logic             memWrite,
    output ctrlPkg::regEnT   regEn,
    output logic             selAr,
    output ctrlPkg::busSelT  busSel,
    output ctrlPkg::incT     incEn,
    output ctrlPkg::clrT     clrEn,
    output ctrlPkg::compSelT compSel,
    output logic             illegalOp
);
    import ctrlPkg::*;

    stateT nextState;   // Sequencer to encoder, same edge for both

    decodeIf decBus ();

    insDecoder insDecoder_i (
        .ir  (ir),
        .dec (decBus.decoder)
    );

    microSequencer microSequencer_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .z         (z),
        .dec       (decBus.sequencer),
        .nextState (nextState),
        .illegalOp (illegalOp)
    );

    ctrlEncoder ctrlEncoder_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .nextState (nextState),
        .iromRead  (iromRead),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .selAr     (selAr),
        .regEn     (regEn),
        .busSel    (busSel),
        .incEn     (incEn),
        .clrEn     (clrEn),
        .compSel   (compSel)
    );

endmodule

`default_nettype wire

/* hw/ctrlEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlEncoder (
    input  logic             Clk,
    input  logic             rstN,
    input  ctrlPkg::stateT   nextState,
    output logic             iromRead,
    output logic             memRead,
    output logic             memWrite,
    output logic             selAr,
    output ctrlPkg::regEnT   regEn,
    output ctrlPkg::busSelT  busSel,
    output ctrlPkg::incT     incEn,
    output ctrlPkg::clrT     clrEn,
    output ctrlPkg::compSelT compSel
);
    import ctrlPkg::*;

    logic    nxtIromRead;
    logic    nxtMemRead;
    logic    nxtMemWrite;
    logic    nxtSelAr;
    regEnT   nxtRegEn;
    busSelT  nxtBusSel;
    incT     nxtIncEn;
    clrT     nxtClrEn;
    compSelT nxtCompSel;

    // Control word of the state about to be entered
    always_comb begin
        nxtIromRead = 1'b0;
        nxtMemRead  = 1'b0;
        nxtMemWrite = 1'b0;
        nxtSelAr    = 1'b0;
        nxtRegEn    = '0;
        nxtBusSel   = busNone;
        nxtIncEn    = '0;
        nxtClrEn    = '0;
        nxtCompSel  = compNone;
        case (nextState)
            fetch1, jmp2, copy1, assign1: nxtIromRead = 1'b1;   // Read IROM at PC
            fetch2: begin
                nxtRegEn[regIr]    = 1'b1;
                nxtIncEn[incBitPc] = 1'b1;
            end
            fetch3, noJmp1: nxtIncEn[incBitPc] = 1'b1;
            jmpM1: nxtCompSel = compM;
            jmpK1: nxtCompSel = compK;
            jmpN1: nxtCompSel = compN;
            jmp3: begin                // AR from IROM, jump target
                nxtRegEn[regAr] = 1'b1;
                nxtSelAr        = 1'b1;
            end
            jmp4: begin
                nxtRegEn[regPc] = 1'b1;
                nxtBusSel       = busAr;
            end
            copy2, assign2: begin      // Operand word into AR, skip past it
                nxtRegEn[regAr]    = 1'b1;
                nxtSelAr           = 1'b1;
                nxtIncEn[incBitPc] = 1'b1;
            end
            copy3, load2: nxtMemRead = 1'b1;
            copy4, load3: begin
                nxtRegEn[regDr] = 1'b1;
                nxtBusSel       = busMem;
            end
            copyM5: begin nxtRegEn[regRm1] = 1'b1; nxtBusSel = busDr; end
            copyK5: begin nxtRegEn[regRk1] = 1'b1; nxtBusSel = busDr; end
            copyN5: begin nxtRegEn[regRn1] = 1'b1; nxtBusSel = busDr; end
            loadC1Ar: begin nxtRegEn[regAr] = 1'b1; nxtBusSel = busC1; end
            loadC2Ar: begin nxtRegEn[regAr] = 1'b1; nxtBusSel = busC2; end
            store1: begin nxtRegEn[regDr] = 1'b1; nxtBusSel = busRt; end   // Result into DR
            store2: begin nxtRegEn[regAr] = 1'b1; nxtBusSel = busC3; end
            store3: begin
                nxtMemWrite = 1'b1;
                nxtBusSel   = busDr;
            end
            assignToC1: begin nxtRegEn[regC1] = 1'b1; nxtBusSel = busAr; end
            assignToC2: begin nxtRegEn[regC2] = 1'b1; nxtBusSel = busAr; end
            assignToC3: begin nxtRegEn[regC3] = 1'b1; nxtBusSel = busAr; end
            exResetAll: begin
                nxtClrEn[clrBitRt]  = 1'b1;
                nxtClrEn[clrBitRm2] = 1'b1;
                nxtClrEn[clrBitRk2] = 1'b1;
                nxtClrEn[clrBitRn2] = 1'b1;
                nxtClrEn[clrBitAc]  = 1'b1;
            end
            exResetN2: nxtClrEn[clrBitRn2] = 1'b1;
            exResetK2: nxtClrEn[clrBitRk2] = 1'b1;
            // Accumulator out to the bus
            exMoveRp: begin nxtRegEn[regRp] = 1'b1; nxtBusSel = busAc; end
            exMoveRt: begin nxtRegEn[regRt] = 1'b1; nxtBusSel = busAc; end
            exMoveC1: begin nxtRegEn[regC1] = 1'b1; nxtBusSel = busAc; end
            exIncC2: nxtIncEn[incBitC2]  = 1'b1;
            exIncC3: nxtIncEn[incBitC3]  = 1'b1;
            exIncM2: nxtIncEn[incBitRm2] = 1'b1;
            exIncK2: nxtIncEn[incBitRk2] = 1'b1;
            exIncN2: nxtIncEn[incBitRn2] = 1'b1;
            default: ;   // idle and noop1 drive nothing
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            iromRead <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            selAr    <= 1'b0;
            regEn    <= '0;
            busSel   <= busNone;
            incEn    <= '0;
            clrEn    <= '0;
            compSel  <= compNone;
        end else begin
            iromRead <= nxtIromRead;
            memRead  <= nxtMemRead;
            memWrite <= nxtMemWrite;
            selAr    <= nxtSelAr;
            regEn    <= nxtRegEn;
            busSel   <= nxtBusSel;
            incEn    <= nxtIncEn;
            clrEn    <= nxtClrEn;
            compSel  <= nxtCompSel;
        end
    end

endmodule

`default_nettype wire

/* hw/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    localparam int stateWidth   = 6;
    localparam int regCount     = 13;
    localparam int busSelWidth  = 4;
    localparam int incCount     = 6;
    localparam int clrCount     = 5;
    localparam int compSelWidth = 3;

    typedef enum logic [stateWidth-1:0] {
        idle, fetch1, fetch2, fetch3,
        noop1,
        jmpM1, jmpK1, jmpN1, jmp2, jmp3, jmp4, noJmp1,
        copy1, copy2, copy3, copy4, copyM5, copyK5, copyN5,
        loadC1Ar, loadC2Ar, load2, load3,
        store1, store2, store3,
        assign1, assign2, assignToC1, assignToC2, assignToC3,
        exResetAll, exResetN2, exResetK2,
        exMoveRp, exMoveRt, exMoveC1,
        exIncC2, exIncC3, exIncM2, exIncK2, exIncN2
    } stateT;

    // Register write enables, one bit per register
    typedef logic [regCount-1:0] regEnT;
    localparam int regPc  = 12;
    localparam int regIr  = 11;
    localparam int regAr  = 10;
    localparam int regDr  = 9;
    localparam int regRp  = 8;
    localparam int regRt  = 7;
    localparam int regRm1 = 6;
    localparam int regRk1 = 5;
    localparam int regRn1 = 4;
    localparam int regC1  = 3;
    localparam int regC2  = 2;
    localparam int regC3  = 1;
    localparam int regAc  = 0;

    typedef enum logic [busSelWidth-1:0] {
        busNone = 4'd0,  busAc  = 4'd1,  busC3  = 4'd2,  busC2  = 4'd3,
        busC1   = 4'd4,  busRn2 = 4'd5,  busRk2 = 4'd6,  busRm2 = 4'd7,
        busRn1  = 4'd8,  busRk1 = 4'd9,  busRm1 = 4'd10, busRt  = 4'd11,
        busRp   = 4'd12, busDr  = 4'd13, busAr  = 4'd14, busMem = 4'd15
    } busSelT;

    typedef logic [incCount-1:0] incT;
    localparam int incBitPc  = 5;
    localparam int incBitRm2 = 4;
    localparam int incBitRk2 = 3;
    localparam int incBitRn2 = 2;
    localparam int incBitC2  = 1;
    localparam int incBitC3  = 0;

    typedef logic [clrCount-1:0] clrT;
    localparam int clrBitRt  = 4;
    localparam int clrBitRm2 = 3;
    localparam int clrBitRk2 = 2;
    localparam int clrBitRn2 = 1;
    localparam int clrBitAc  = 0;

    // One-hot, drives both comparator input muxes
    typedef enum logic [compSelWidth-1:0] {
        compNone = 3'b000,
        compM    = 3'b100,
        compK    = 3'b010,
        compN    = 3'b001
    } compSelT;

endpackage

`default_nettype wire

/* hw/decodeIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
    import ctrlPkg::*;
    import isaPkg::*;

    stateT entryState;   // First micro-state of the routine
    destT  copyDest;
    destT  assignDest;
    logic  illegal;

    modport decoder (
        output entryState, copyDest, assignDest, illegal
    );

    modport sequencer (
        input entryState, copyDest, assignDest, illegal
    );

endinterface

`default_nettype wire

/* hw/insDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insDecoder (
    input isaPkg::insT ir,
    decodeIf.decoder   dec
);
    import ctrlPkg::*;
    import isaPkg::*;

    opcodeT  opcode;
    subCodeT subCode;
    destT    dest;

    assign opcode  = opcodeT'(ir[7:4]);
    assign subCode = ir[3:0];
    assign dest    = destT'(ir[1:0]);

    // Both routines read the same field
    assign dec.copyDest   = dest;
    assign dec.assignDest = dest;

    always_comb begin
        dec.entryState = fetch1;   // Restart fetch on anything illegal
        dec.illegal    = 1'b0;
        case (opcode)
            opNoop:  dec.entryState = noop1;
            opStore: dec.entryState = store1;
            opJmp: begin
                case (subCode)
                    jmpM:    dec.entryState = jmpM1;
                    jmpK:    dec.entryState = jmpK1;
                    jmpN:    dec.entryState = jmpN1;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opCopy: begin
                if (dest == destInvalid) dec.illegal = 1'b1;
                else dec.entryState = copy1;
            end
            opAssign: begin
                if (dest == destInvalid) dec.illegal = 1'b1;
                else dec.entryState = assign1;
            end
            opLoad: begin
                case (subCode)
                    loadC1:  dec.entryState = loadC1Ar;
                    loadC2:  dec.entryState = loadC2Ar;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opReset: begin
                case (subCode)
                    resetAll: dec.entryState = exResetAll;
                    resetN2:  dec.entryState = exResetN2;
                    resetK2:  dec.entryState = exResetK2;
                    default:  dec.illegal = 1'b1;
                endcase
            end
            opMove: begin
                case (subCode)
                    moveRp:  dec.entryState = exMoveRp;
                    moveRt:  dec.entryState = exMoveRt;
                    moveC1:  dec.entryState = exMoveC1;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opInc: begin
                case (subCode)
                    incC2:   dec.entryState = exIncC2;
                    incC3:   dec.entryState = exIncC3;
                    incM2:   dec.entryState = exIncM2;
                    incK2:   dec.entryState = exIncK2;
                    incN2:   dec.entryState = exIncN2;
                    default: dec.illegal = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;   // Unassigned opcode
        endcase
    end

endmodule

`default_nettype wire

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int insWidth  = 8;
    localparam int opWidth   = 4;
    localparam int subWidth  = 4;
    localparam int destWidth = 2;

    typedef logic [insWidth-1:0] insT;   // Instruction byte as held in IR
    typedef logic [subWidth-1:0] subCodeT;

    // Upper nibble of the instruction byte
    typedef enum logic [opWidth-1:0] {
        opNoop   = 4'h0,
        opJmp    = 4'h1,
        opCopy   = 4'h2,
        opLoad   = 4'h3,
        opStore  = 4'h4,
        opAssign = 4'h5,
        opReset  = 4'h6,
        opMove   = 4'h7,
        opInc    = 4'h8
    } opcodeT;

    // JMP compares register pair x1 against x2
    localparam subCodeT jmpM = 4'h0;
    localparam subCodeT jmpK = 4'h1;
    localparam subCodeT jmpN = 4'h2;

    localparam subCodeT loadC1 = 4'h0;   // Address taken from C1
    localparam subCodeT loadC2 = 4'h1;

    localparam subCodeT resetAll = 4'h0;
    localparam subCodeT resetN2  = 4'h1;
    localparam subCodeT resetK2  = 4'h2;

    localparam subCodeT moveRp = 4'h0;   // AC to RP
    localparam subCodeT moveRt = 4'h1;
    localparam subCodeT moveC1 = 4'h2;

    localparam subCodeT incC2 = 4'h0;
    localparam subCodeT incC3 = 4'h1;
    localparam subCodeT incM2 = 4'h2;
    localparam subCodeT incK2 = 4'h3;
    localparam subCodeT incN2 = 4'h4;

    // Low two bits of COPY and ASSIGN
    // M1/K1/N1 for COPY, C1/C2/C3 for ASSIGN
    typedef enum logic [destWidth-1:0] {
        destFirst   = 2'd0,
        destSecond  = 2'd1,
        destThird   = 2'd2,
        destInvalid = 2'd3
    } destT;

endpackage

`default_nettype wire

/* hw/microSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencer (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          z,
    decodeIf.sequencer    dec,
    output ctrlPkg::stateT nextState,
    output logic          illegalOp
);
    import ctrlPkg::*;
    import isaPkg::*;

    stateT state;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state     <= idle;
            illegalOp <= 1'b0;
        end else begin
            state     <= nextState;
            // Flag lands in the fetch1 that follows the bad decode
            illegalOp <= (state == fetch3) && dec.illegal;
        end
    end

    always_comb begin
        nextState = fetch1;   // Single-step routines all return here
        case (state)
            idle:   nextState = fetch1;
            fetch1: nextState = fetch2;
            fetch2: nextState = fetch3;
            fetch3: begin
                // IR was loaded on the edge that ended fetch2
                if (dec.illegal) nextState = fetch1;
                else nextState = dec.entryState;
            end

            // Compare states, z high means equal so no jump
            jmpM1, jmpK1, jmpN1: begin
                if (z) nextState = noJmp1;
                else nextState = jmp2;
            end
            jmp2: nextState = jmp3;
            jmp3: nextState = jmp4;

            copy1: nextState = copy2;
            copy2: nextState = copy3;
            copy3: nextState = copy4;
            copy4: begin
                case (dec.copyDest)
                    destFirst:  nextState = copyM5;
                    destSecond: nextState = copyK5;
                    destThird:  nextState = copyN5;
                    default:    nextState = fetch1;
                endcase
            end

            loadC1Ar, loadC2Ar: nextState = load2;
            load2:              nextState = load3;

            store1: nextState = store2;
            store2: nextState = store3;

            assign1: nextState = assign2;
            assign2: begin
                case (dec.assignDest)
                    destFirst:  nextState = assignToC1;
                    destSecond: nextState = assignToC2;
                    destThird:  nextState = assignToC3;
                    default:    nextState = fetch1;
                endcase
            end

            default: nextState = fetch1;
        endcase
    end

endmodule

`default_nettype wire

/* tb/cpuControlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuControlTb;
    import ctrlPkg::*;
    import isaPkg::*;

    localparam string dataFile = "tb/cpuControl_testdata.txt";

    logic     Clk = 1'b0;
    logic     rstN;
    insT      ir;
    logic     z;
    logic     iromRead;
    logic     memRead;
    logic     memWrite;
    regEnT    regEn;
    logic     selAr;
    busSelT   busSel;
    incT      incEn;
    clrT      clrEn;
    compSelT  compSel;
    logic     illegalOp;

    logic [35:0] testData [0:511];   // Record count first, then the records
    insT      curIns = '0;
    logic     curZ = 1'b0;
    int       cycleCount = 0;
    int       cycleLimit = 0;        // Zero until the data file is walked

    always #50 Clk = ~Clk;

    cpuControl dut_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .ir        (ir),
        .z         (z),
        .iromRead  (iromRead),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .regEn     (regEn),
        .selAr     (selAr),
        .busSel    (busSel),
        .incEn     (incEn),
        .clrEn     (clrEn),
        .compSel   (compSel),
        .illegalOp (illegalOp)
    );

    // IR model, loads on the edge that ends fetch2
    always @(posedge Clk) begin
        if (regEn[regIr]) begin
            ir <= curIns;
            z  <= curZ;   // Held for the whole routine
        end
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit)
            failRun($sformatf("run hung, still going after %0d cycles", cycleCount));
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    function automatic string strobeName(input int idx);
        case (idx)
            4: return "iromRead";
            3: return "memRead";
            2: return "memWrite";
            1: return "selAr";
            default: return "illegalOp";
        endcase
    endfunction

    task automatic checkStrobes(input logic [4:0] expVal, input logic [4:0] actVal);
        for (int i = 4; i >= 0; i--) begin
            if (actVal[i] !== expVal[i])
                failRun($sformatf("error at %0d ns: %s expected %b, got %b",
                    $time, strobeName(i), expVal[i], actVal[i]));
        end
    endtask

    task automatic checkRegEn(input regEnT expVal, input regEnT actVal);
        if (actVal !== expVal)
            failRun($sformatf("error at %0d ns: regEn expected %h, got %h",
                $time, expVal, actVal));
    endtask

    task automatic checkBusSel(input busSelT expVal, input busSelT actVal);
        if (actVal !== expVal)
            failRun($sformatf("error at %0d ns: busSel expected %0d, got %0d",
                $time, expVal, actVal));
    endtask

    task automatic checkIncEn(input incT expVal, input incT actVal);
        if (actVal !== expVal)
            failRun($sformatf("error at %0d ns: incEn expected %b, got %b",
                $time, expVal, actVal));
    endtask

    task automatic checkClrEn(input clrT expVal, input clrT actVal);
        if (actVal !== expVal)
            failRun($sformatf("error at %0d ns: clrEn expected %b, got %b",
                $time, expVal, actVal));
    endtask

    task automatic checkCompSel(input compSelT expVal, input compSelT actVal);
        if (actVal !== expVal)
            failRun($sformatf("error at %0d ns: compSel expected %b, got %b",
                $time, expVal, actVal));
    endtask

    // Word layout as in the data file header
    task automatic checkWord(input logic [35:0] word);
        checkStrobes(word[35:31], {iromRead, memRead, memWrite, selAr, illegalOp});
        checkRegEn(word[30:18], regEn);
        checkBusSel(busSelT'(word[17:14]), busSel);
        checkIncEn(word[13:8], incEn);
        checkClrEn(word[7:3], clrEn);
        checkCompSel(compSelT'(word[2:0]), compSel);
    endtask

    initial begin
        int ptr;
        int recCount;
        int cycles;
        int total;
        rstN = 1'b0;
        ir   = '0;
        z    = 1'b0;
        $readmemh(dataFile, testData);
        if (^testData[0] === 1'bx || testData[0] == '0)
            failRun("test data file is missing or holds no records");
        recCount = int'(testData[0]);

        total = 0;
        ptr   = 1;
        for (int r = 0; r < recCount; r++) begin
            cycles = int'(testData[ptr + 2]);
            total += cycles;
            ptr   += 3 + cycles;
        end
        cycleLimit = total + 20;

        repeat (5) @(posedge Clk);
        rstN <= 1'b1;
        @(negedge Clk);
        checkWord('0);   // Idle cycle before the first fetch

        ptr = 1;
        for (int r = 0; r < recCount; r++) begin
            curIns = insT'(testData[ptr][7:0]);
            curZ   = testData[ptr + 1][0];
            cycles = int'(testData[ptr + 2]);
            ptr   += 3;
            for (int c = 0; c < cycles; c++) begin
                @(negedge Clk);   // Mid-cycle, outputs settled
                checkWord(testData[ptr]);
                ptr++;
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpuControl_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuControlAssert (
    input logic             Clk,
    input logic             rstN,
    input logic             iromRead,
    input logic             memRead,
    input logic             memWrite,
    input logic             selAr,
    input logic             illegalOp,
    input ctrlPkg::regEnT   regEn,
    input ctrlPkg::busSelT  busSel,
    input ctrlPkg::incT     incEn,
    input ctrlPkg::clrT     clrEn,
    input ctrlPkg::compSelT compSel
);
    import ctrlPkg::*;

    memExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(memRead && memWrite))
        else $error("memRead and memWrite high together");

    // Compare cycles leave the bus and registers alone
    compareQuiet: assert property (@(posedge Clk) disable iff (!rstN)
        (compSel != compNone) |-> (regEn == '0 && busSel == busNone))
        else $error("compSel active with a bus transfer or register write");

    // Illegal flag arrives with the fetch restart
    illegalRefetch: assert property (@(posedge Clk) disable iff (!rstN)
        illegalOp |-> iromRead)
        else $error("illegalOp without a fetch restart");

    idleAfterReset: assert property (@(posedge Clk)
        $rose(rstN) |-> (!iromRead && !memRead && !memWrite && !selAr && !illegalOp
            && regEn == '0 && busSel == busNone && incEn == '0 && clrEn == '0
            && compSel == compNone))
        else $error("control outputs active right after reset");

endmodule

bind cpuControl cpuControlAssert cpuControlAssert_i (
    .Clk       (Clk),
    .rstN      (rstN),
    .iromRead  (iromRead),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .selAr     (selAr),
    .illegalOp (illegalOp),
    .regEn     (regEn),
    .busSel    (busSel),
    .incEn     (incEn),
    .clrEn     (clrEn),
    .compSel   (compSel)
);

`default_nettype wire

/* tb/cpuControl_testdata.txt */
// First word is the record count. Each record: instruction byte, z, cycle count,
// then one expected control word per cycle, starting at fetch1
// Word bits: 35 iromRead, 34 memRead, 33 memWrite, 32 selAr, 31 illegalOp,
// 30:18 regEn, 17:14 busSel, 13:8 incEn, 7:3 clrEn, 2:0 compSel
1F
00 0 4 800000000 020002000 000002000 000000000
10 1 5 800000000 020002000 000002000 000000004 000002000
10 0 7 800000000 020002000 000002000 000000004 800000000 110000000 040038000
11 1 5 800000000 020002000 000002000 000000002 000002000
11 0 7 800000000 020002000 000002000 000000002 800000000 110000000 040038000
12 1 5 800000000 020002000 000002000 000000001 000002000
12 0 7 800000000 020002000 000002000 000000001 800000000 110000000 040038000
20 0 8 800000000 020002000 000002000 800000000 110002000 400000000 00803C000 001034000
21 0 8 800000000 020002000 000002000 800000000 110002000 400000000 00803C000 000834000
22 0 8 800000000 020002000 000002000 800000000 110002000 400000000 00803C000 000434000
50 0 6 800000000 020002000 000002000 800000000 110002000 000238000
51 0 6 800000000 020002000 000002000 800000000 110002000 000138000
52 0 6 800000000 020002000 000002000 800000000 110002000 0000B8000
30 0 6 800000000 020002000 000002000 010010000 400000000 00803C000
31 0 6 800000000 020002000 000002000 01000C000 400000000 00803C000
40 0 6 800000000 020002000 000002000 00802C000 010008000 200034000
60 0 4 800000000 020002000 000002000 0000000F8
61 0 4 800000000 020002000 000002000 000000010
62 0 4 800000000 020002000 000002000 000000020
70 0 4 800000000 020002000 000002000 004004000
71 0 4 800000000 020002000 000002000 002004000
72 0 4 800000000 020002000 000002000 000204000
80 0 4 800000000 020002000 000002000 000000200
81 0 4 800000000 020002000 000002000 000000100
82 0 4 800000000 020002000 000002000 000001000
83 0 4 800000000 020002000 000002000 000000800
84 0 4 800000000 020002000 000002000 000000400
95 0 3 800000000 020002000 000002000
00 0 4 880000000 020002000 000002000 000000000
23 0 3 800000000 020002000 000002000
40 0 6 880000000 020002000 000002000 00802C000 010008000 200034000
